/* issue_stage.f */
hdl/issue_pkg.sv
hdl/sb_iro_if.sv
hdl/scoreboard.sv
hdl/issue_read_operands.sv
hdl/regfile.sv
hdl/issue_stage.sv
dv/tb_issue_stage.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_issue_stage
FILELIST  := issue_stage.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_issue_stage.sv */
// Issue stage testbench with clock, reset, program stimulus, unit model, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage import issue_pkg::*; ();

  localparam int unsigned NR_SB_ENTRIES = 4;
  localparam int          N_INSTR       = 200;
  localparam int          N_REGS_USED   = 6;
  localparam int          TIMEOUT       = 2000;
  localparam int          RUN_TIMEOUT   = 20000;
  localparam int          CHK_W         = 96;
  localparam logic [XLEN-1:0] MEM_VALUE = 32'h5a5a5a5a;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i;
  sb_entry_t                decoded_instr_i;
  logic                     decoded_valid_i;
  logic                     decoded_ready_o;
  logic                     sb_full_o;
  fu_data_t                 fu_data_o;
  logic                     alu_valid_o;
  logic                     alu_ready_i;
  logic                     lsu_valid_o;
  logic                     lsu_ready_i;
  logic                     wb_valid_i;
  logic [TRANS_ID_BITS-1:0] wb_trans_id_i;
  logic [XLEN-1:0]          wb_data_i;
  logic                     commit_valid_o;
  logic                     commit_ack_i;
  logic [REG_ADDR_BITS-1:0] commit_rd_o;
  logic [XLEN-1:0]          commit_data_o;
  logic [TRANS_ID_BITS-1:0] commit_trans_id_o;

  // Program and its expected results
  sb_entry_t                prog     [N_INSTR];
  logic [XLEN-1:0]          exp_data [N_INSTR];
  int                       commit_cnt = 0;
  logic                     hold_commit = 1'b1;

  // Unit model state with results waiting for writeback
  logic [TRANS_ID_BITS-1:0] wb_tid_q  [$];
  logic [XLEN-1:0]          wb_data_q [$];
  logic                     hold_pend = 1'b0;
  logic [1:0]               held_valid;
  fu_data_t                 held_data;

  issue_stage #(
    .NR_SB_ENTRIES(NR_SB_ENTRIES)
  ) uut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .decoded_instr_i  (decoded_instr_i),
    .decoded_valid_i  (decoded_valid_i),
    .decoded_ready_o  (decoded_ready_o),
    .sb_full_o        (sb_full_o),
    .fu_data_o        (fu_data_o),
    .alu_valid_o      (alu_valid_o),
    .alu_ready_i      (alu_ready_i),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_ready_i      (lsu_ready_i),
    .wb_valid_i       (wb_valid_i),
    .wb_trans_id_i    (wb_trans_id_i),
    .wb_data_i        (wb_data_i),
    .commit_valid_o   (commit_valid_o),
    .commit_ack_i     (commit_ack_i),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_trans_id_o(commit_trans_id_o)
  );

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------
  // Failure reporting and models
  // --------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic value_mismatch(input string test, input logic [CHK_W-1:0] expected,
                                input logic [CHK_W-1:0] actual);
    abort_run($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
                        test, expected, actual));
  endtask

  // Unit behaviour per op where LDA adds the address and mixes in a fixed memory word
  function automatic logic [XLEN-1:0] compute_op(input op_t op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return (a + b) ^ MEM_VALUE;
    endcase
  endfunction

  // Few registers in use so that most sources depend on recent results
  function automatic void make_program();
    for (int i = 0; i < N_INSTR; i++) begin
      prog[i]     = '0;
      prog[i].op  = op_t'(3'($urandom % 5));
      prog[i].rd  = REG_ADDR_BITS'($urandom % N_REGS_USED);
      prog[i].rs1 = REG_ADDR_BITS'($urandom % N_REGS_USED);
      prog[i].rs2 = REG_ADDR_BITS'($urandom % N_REGS_USED);
      // Every tenth loads into x0 and the next one reads x0 back
      if (i % 10 == 0) begin
        prog[i].op = OP_LDA;
        prog[i].rd = '0;
      end
      if (i % 10 == 1) begin
        prog[i].rs1 = '0;
      end
      prog[i].fu = (prog[i].op == OP_LDA) ? FU_LSU : FU_ALU;
    end
  endfunction

  // In-order execution on a model register file that never writes x0
  function automatic void run_reference();
    logic [XLEN-1:0] regs [2**REG_ADDR_BITS];
    logic [XLEN-1:0] result;
    for (int r = 0; r < 2**REG_ADDR_BITS; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < N_INSTR; i++) begin
      result      = compute_op(prog[i].op, regs[prog[i].rs1], regs[prog[i].rs2]);
      exp_data[i] = result;
      if (prog[i].rd != '0) begin
        regs[prog[i].rd] = result;
      end
    end
  endfunction

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_instr(input int idx);
    int waited;
    waited          = 0;
    decoded_instr_i = prog[idx];
    decoded_valid_i = 1'b1;
    while (!decoded_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("Timeout: an instruction was never accepted by the scoreboard");
      end
    end
    @(negedge clk_i);
    decoded_valid_i = 1'b0;
  endtask

  // --------------------------------------------------
  // Functional unit model
  // --------------------------------------------------
  always @(negedge clk_i) begin
    int j;
    if (!rst_n_i) begin
      alu_ready_i = 1'b0;
      lsu_ready_i = 1'b0;
      wb_valid_i  = 1'b0;
      hold_pend   = 1'b0;
    end else begin
      // Stalled dispatch still there and unchanged
      if (hold_pend) begin
        assert ({alu_valid_o, lsu_valid_o} == held_valid)
          else value_mismatch("dispatch valid hold", CHK_W'(held_valid),
                              CHK_W'({alu_valid_o, lsu_valid_o}));
        assert (fu_data_o == held_data)
          else value_mismatch("dispatch data hold", CHK_W'(held_data), CHK_W'(fu_data_o));
      end
      // Loads go to the LSU and every other op to the ALU
      if (alu_valid_o || lsu_valid_o) begin
        assert (lsu_valid_o == (fu_data_o.op == OP_LDA))
          else value_mismatch("dispatch unit", CHK_W'(fu_data_o.op == OP_LDA),
                              CHK_W'(lsu_valid_o));
      end
      // One writeback per cycle picked at random among the finished ones
      wb_valid_i = 1'b0;
      if (wb_tid_q.size() > 0 && ($urandom % 2) == 0) begin
        j             = int'($urandom % wb_tid_q.size());
        wb_valid_i    = 1'b1;
        wb_trans_id_i = wb_tid_q[j];
        wb_data_i     = wb_data_q[j];
        wb_tid_q.delete(j);
        wb_data_q.delete(j);
      end
      alu_ready_i = ($urandom % 4) != 0;
      lsu_ready_i = ($urandom % 3) != 0;
      // Accepted at the coming rising edge
      if ((alu_valid_o && alu_ready_i) || (lsu_valid_o && lsu_ready_i)) begin
        wb_tid_q.push_back(fu_data_o.trans_id);
        wb_data_q.push_back(compute_op(fu_data_o.op, fu_data_o.operand_a,
                                       fu_data_o.operand_b));
      end
      hold_pend  = (alu_valid_o && !alu_ready_i) || (lsu_valid_o && !lsu_ready_i);
      held_valid = {alu_valid_o, lsu_valid_o};
      held_data  = fu_data_o;
    end
  end

  // --------------------------------------------------
  // Commit compare
  // --------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_n_i || hold_commit) begin
      commit_ack_i = 1'b0;
    end else begin
      commit_ack_i = ($urandom % 3) != 0;
    end
    if (commit_valid_o && commit_ack_i) begin
      assert (commit_cnt < N_INSTR)
        else abort_run("A commit appeared after the whole program had committed");
      // Ids wrap with the buffer size so order shows in the id sequence
      assert (commit_trans_id_o == TRANS_ID_BITS'(commit_cnt % NR_SB_ENTRIES))
        else value_mismatch("commit order", CHK_W'(commit_cnt % NR_SB_ENTRIES),
                            CHK_W'(commit_trans_id_o));
      assert (commit_rd_o == prog[commit_cnt].rd)
        else value_mismatch("commit rd", CHK_W'(prog[commit_cnt].rd), CHK_W'(commit_rd_o));
      assert (commit_data_o == exp_data[commit_cnt])
        else value_mismatch("commit data", CHK_W'(exp_data[commit_cnt]),
                            CHK_W'(commit_data_o));
      commit_cnt++;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int waited;
    void'($urandom(32'h46b1b3bd));
    rst_n_i         = 1'b0;
    decoded_instr_i = '0;
    decoded_valid_i = 1'b0;
    alu_ready_i     = 1'b0;
    lsu_ready_i     = 1'b0;
    wb_valid_i      = 1'b0;
    wb_trans_id_i   = '0;
    wb_data_i       = '0;
    commit_ack_i    = 1'b0;
    make_program();
    run_reference();
    repeat (5) @(negedge clk_i);
    rst_n_i <= 1'b1;

    // Idle state right out of reset
    assert (decoded_ready_o == 1'b1)
      else value_mismatch("reset decoded_ready_o", CHK_W'(1), CHK_W'(decoded_ready_o));
    assert ({alu_valid_o, lsu_valid_o, commit_valid_o, sb_full_o} == 4'b0000)
      else value_mismatch("reset valids and full", CHK_W'(0),
                          CHK_W'({alu_valid_o, lsu_valid_o, commit_valid_o, sb_full_o}));
    @(negedge clk_i);

    // Four accepted with commit held fill the buffer
    for (int i = 0; i < 4; i++) begin
      send_instr(i);
    end
    assert (sb_full_o == 1'b1 && decoded_ready_o == 1'b0)
      else value_mismatch("full after four", CHK_W'(2'b10),
                          CHK_W'({sb_full_o, decoded_ready_o}));
    decoded_instr_i = prog[4];
    decoded_valid_i = 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      assert (decoded_ready_o == 1'b0)
        else value_mismatch("fifth stays out", CHK_W'(0), CHK_W'(decoded_ready_o));
    end

    // One acknowledged commit frees a slot
    hold_commit <= 1'b0;
    waited      = 0;
    while (!decoded_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("Timeout: scoreboard stayed full after commit was released");
      end
    end
    assert (sb_full_o == 1'b0 && commit_cnt > 0)
      else value_mismatch("full after commit", CHK_W'(0), CHK_W'(sb_full_o));
    send_instr(4);

    // Rest of the program with random gaps
    for (int i = 5; i < N_INSTR; i++) begin
      repeat ($urandom % 3) @(negedge clk_i);
      send_instr(i);
    end

    waited = 0;
    while (commit_cnt < N_INSTR) begin
      @(negedge clk_i);
      waited++;
      if (waited > RUN_TIMEOUT) begin
        abort_run("Timeout: not every instruction committed");
      end
    end
    @(negedge clk_i);

    if (wb_tid_q.size() == 0 && !alu_valid_o && !lsu_valid_o) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("Work was left in flight after the last commit");
    end
  end

endmodule

`default_nettype wire

/* hdl/issue_stage.sv */
// Issue stage top level joining scoreboard, operand read and register file
`timescale 1ns/1ps
`default_nettype none

module issue_stage import issue_pkg::*; #(
  parameter int unsigned NR_SB_ENTRIES = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // From decode
  input  sb_entry_t                decoded_instr_i,
  input  logic                     decoded_valid_i,
  output logic                     decoded_ready_o,
  output logic                     sb_full_o,
  // To the functional units
  output fu_data_t                 fu_data_o,
  output logic                     alu_valid_o,
  input  logic                     alu_ready_i,
  output logic                     lsu_valid_o,
  input  logic                     lsu_ready_i,
  // Writeback
  input  logic                     wb_valid_i,
  input  logic [TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  logic [XLEN-1:0]          wb_data_i,
  // Commit
  output logic                     commit_valid_o,
  input  logic                     commit_ack_i,
  output logic [REG_ADDR_BITS-1:0] commit_rd_o,
  output logic [XLEN-1:0]          commit_data_o,
  output logic [TRANS_ID_BITS-1:0] commit_trans_id_o
);

  // Register file wiring
  logic                     rf_we;
  logic [REG_ADDR_BITS-1:0] rf_waddr;
  logic [XLEN-1:0]          rf_wdata;
  logic [REG_ADDR_BITS-1:0] rf_raddr_a;
  logic [REG_ADDR_BITS-1:0] rf_raddr_b;
  logic [XLEN-1:0]          rf_rdata_a;
  logic [XLEN-1:0]          rf_rdata_b;

  sb_iro_if #(.NR_SB_ENTRIES(NR_SB_ENTRIES)) sb_iro ();

  // ------------------------------------------------
  // Scoreboard
  // ------------------------------------------------
  scoreboard #(
    .NR_SB_ENTRIES(NR_SB_ENTRIES)
  ) i_scoreboard (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .decoded_instr_i  (decoded_instr_i),
    .decoded_valid_i  (decoded_valid_i),
    .decoded_ready_o  (decoded_ready_o),
    .sb_full_o        (sb_full_o),
    .wb_valid_i       (wb_valid_i),
    .wb_trans_id_i    (wb_trans_id_i),
    .wb_data_i        (wb_data_i),
    .commit_valid_o   (commit_valid_o),
    .commit_ack_i     (commit_ack_i),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_trans_id_o(commit_trans_id_o),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .sb               (sb_iro.sb)
  );

  // ------------------------------------------------
  // Operand read and dispatch
  // ------------------------------------------------
  issue_read_operands i_issue_read_operands (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .iro         (sb_iro.iro),
    .rf_raddr_a_o(rf_raddr_a),
    .rf_raddr_b_o(rf_raddr_b),
    .rf_rdata_a_i(rf_rdata_a),
    .rf_rdata_b_i(rf_rdata_b),
    .fu_data_o   (fu_data_o),
    .alu_valid_o (alu_valid_o),
    .alu_ready_i (alu_ready_i),
    .lsu_valid_o (lsu_valid_o),
    .lsu_ready_i (lsu_ready_i)
  );

  // Architectural state, written at commit
  regfile i_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .raddr_a_i(rf_raddr_a),
    .raddr_b_i(rf_raddr_b),
    .rdata_a_o(rf_rdata_a),
    .rdata_b_o(rf_rdata_b),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

endmodule

`default_nettype wire

/* hdl/regfile.sv */
// Register file with 32 entries, two combinational read ports, one write port, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module regfile import issue_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [REG_ADDR_BITS-1:0] raddr_a_i,
  input  logic [REG_ADDR_BITS-1:0] raddr_b_i,
  output logic [XLEN-1:0]          rdata_a_o,
  output logic [XLEN-1:0]          rdata_b_o,
  input  logic                     we_i,
  input  logic [REG_ADDR_BITS-1:0] waddr_i,
  input  logic [XLEN-1:0]          wdata_i
);

  localparam int unsigned NR_REGS = 2**REG_ADDR_BITS;

  // No storage behind x0
  logic [XLEN-1:0] regs [1:NR_REGS-1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 1; r < NR_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Reads bypass nothing, a write shows up the cycle after
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* hdl/issue_read_operands.sv */
// Operand read with hazard check, forwarding select and registered ALU or LSU dispatch
`timescale 1ns/1ps
`default_nettype none

module issue_read_operands import issue_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Scoreboard side
  sb_iro_if.iro                    iro,
  // Register file read ports
  output logic [REG_ADDR_BITS-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_BITS-1:0] rf_raddr_b_o,
  input  logic [XLEN-1:0]          rf_rdata_a_i,
  input  logic [XLEN-1:0]          rf_rdata_b_i,
  // Dispatch to the units
  output fu_data_t                 fu_data_o,
  output logic                     alu_valid_o,
  input  logic                     alu_ready_i,
  output logic                     lsu_valid_o,
  input  logic                     lsu_ready_i
);

  sb_entry_t       instr;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic            a_stall;
  logic            b_stall;
  logic            out_free;
  fu_data_t        fu_data_q;
  logic            alu_valid_q;
  logic            lsu_valid_q;

  assign instr = iro.issue_instr;

  // Sources go to both the scoreboard lookup and the register file
  assign iro.rs1      = instr.rs1;
  assign iro.rs2      = instr.rs2;
  assign rf_raddr_a_o = instr.rs1;
  assign rf_raddr_b_o = instr.rs2;

  // ------------------------------------------------
  // Operand select and hazard check
  // ------------------------------------------------
  // Clobbered source takes the youngest producer's result
  assign operand_a = iro.rd_clobber[instr.rs1] ? iro.rs1_fwd_data : rf_rdata_a_i;
  assign operand_b = iro.rd_clobber[instr.rs2] ? iro.rs2_fwd_data : rf_rdata_b_i;

  // RAW hazard, producer issued but not yet written back
  assign a_stall = iro.rd_clobber[instr.rs1] & ~iro.rs1_fwd_valid;
  assign b_stall = iro.rd_clobber[instr.rs2] & ~iro.rs2_fwd_valid;

  // Output register is free when empty or handed over this cycle
  assign out_free = ~(alu_valid_q | lsu_valid_q) |
                    (alu_valid_q & alu_ready_i) |
                    (lsu_valid_q & lsu_ready_i);

  assign iro.issue_ack = iro.issue_valid & ~a_stall & ~b_stall & out_free;

  // ------------------------------------------------
  // Dispatch register
  // ------------------------------------------------
  // Valids held until the unit accepts
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alu_valid_q <= 1'b0;
      lsu_valid_q <= 1'b0;
    end else if (iro.issue_ack) begin
      alu_valid_q <= (instr.fu == FU_ALU);
      lsu_valid_q <= (instr.fu == FU_LSU);
    end else begin
      if (alu_ready_i) begin
        alu_valid_q <= 1'b0;
      end
      if (lsu_ready_i) begin
        lsu_valid_q <= 1'b0;
      end
    end
  end

  // Shared payload for both units
  always_ff @(posedge clk_i) begin
    if (iro.issue_ack) begin
      fu_data_q.op        <= instr.op;
      fu_data_q.operand_a <= operand_a;
      fu_data_q.operand_b <= operand_b;
      fu_data_q.trans_id  <= TRANS_ID_BITS'(iro.issue_id);
    end
  end

  assign fu_data_o   = fu_data_q;
  assign alu_valid_o = alu_valid_q;
  assign lsu_valid_o = lsu_valid_q;

  // ------------------------------------------------
  // Assertions
  // ------------------------------------------------
  a_one_unit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(alu_valid_o && lsu_valid_o));

  // Stalled dispatch keeps its payload until accepted
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((alu_valid_o && !alu_ready_i) || (lsu_valid_o && !lsu_ready_i)) |=>
      $stable(fu_data_o) && $stable({alu_valid_o, lsu_valid_o}));

endmodule

`default_nettype wire

/* hdl/scoreboard.sv */
// Scoreboard with circular entry buffer, clobber tracking, operand forwarding and in-order commit
`timescale 1ns/1ps
`default_nettype none

module scoreboard import issue_pkg::*; #(
  parameter int unsigned NR_SB_ENTRIES = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Decoded instructions in
  input  sb_entry_t                decoded_instr_i,
  input  logic                     decoded_valid_i,
  output logic                     decoded_ready_o,
  output logic                     sb_full_o,
  // Writeback from the functional units
  input  logic                     wb_valid_i,
  input  logic [TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  logic [XLEN-1:0]          wb_data_i,
  // Commit port
  output logic                     commit_valid_o,
  input  logic                     commit_ack_i,
  output logic [REG_ADDR_BITS-1:0] commit_rd_o,
  output logic [XLEN-1:0]          commit_data_o,
  output logic [TRANS_ID_BITS-1:0] commit_trans_id_o,
  // Register file write
  output logic                     rf_we_o,
  output logic [REG_ADDR_BITS-1:0] rf_waddr_o,
  output logic [XLEN-1:0]          rf_wdata_o,
  // Towards operand read
  sb_iro_if.sb                     sb
);

  localparam int unsigned TID_W = $clog2(NR_SB_ENTRIES);

  typedef logic [TID_W-1:0] ptr_t;

  // Per-slot control state
  logic [NR_SB_ENTRIES-1:0] valid_q;
  logic [NR_SB_ENTRIES-1:0] issued_q;
  logic [NR_SB_ENTRIES-1:0] done_q;

  // Per-slot payload
  sb_entry_t                instr_q  [NR_SB_ENTRIES];
  logic [XLEN-1:0]          result_q [NR_SB_ENTRIES];

  ptr_t                     wr_ptr_q;
  ptr_t                     issue_ptr_q;
  ptr_t                     commit_ptr_q;
  ptr_t                     wb_id;
  sb_entry_t                alloc_entry;
  logic                     alloc;
  logic                     issue_fire;
  logic                     commit_fire;

  // ------------------------------------------------
  // Handshakes
  // ------------------------------------------------
  // Slot under the write pointer still taken means every slot is taken
  assign sb_full_o       = valid_q[wr_ptr_q];
  assign decoded_ready_o = ~sb_full_o;
  assign alloc           = decoded_valid_i & decoded_ready_o;

  assign sb.issue_instr  = instr_q[issue_ptr_q];
  assign sb.issue_id     = issue_ptr_q;
  assign sb.issue_valid  = valid_q[issue_ptr_q] & ~issued_q[issue_ptr_q];
  assign issue_fire      = sb.issue_valid & sb.issue_ack;

  // Head of the buffer commits once its result is in
  assign commit_valid_o    = valid_q[commit_ptr_q] & done_q[commit_ptr_q];
  assign commit_rd_o       = instr_q[commit_ptr_q].rd;
  assign commit_data_o     = result_q[commit_ptr_q];
  assign commit_trans_id_o = instr_q[commit_ptr_q].trans_id;
  assign commit_fire       = commit_valid_o & commit_ack_i;

  // x0 results commit but never reach the register file
  assign rf_we_o    = commit_fire & (commit_rd_o != '0);
  assign rf_waddr_o = commit_rd_o;
  assign rf_wdata_o = commit_data_o;

  assign wb_id = wb_trans_id_i[TID_W-1:0];

  // Slot index becomes the transaction id
  always_comb begin
    alloc_entry          = decoded_instr_i;
    alloc_entry.trans_id = TRANS_ID_BITS'(wr_ptr_q);
  end

  // ------------------------------------------------
  // Clobber vector and forwarding
  // ------------------------------------------------
  // Only issued slots count, so the head instruction never sees itself
  // Walk oldest to youngest, a later match overrides an earlier one
  always_comb begin
    ptr_t idx;
    sb.rd_clobber    = '0;
    sb.rs1_fwd_data  = '0;
    sb.rs1_fwd_valid = 1'b0;
    sb.rs2_fwd_data  = '0;
    sb.rs2_fwd_valid = 1'b0;
    for (int k = 0; k < NR_SB_ENTRIES; k++) begin
      idx = commit_ptr_q + ptr_t'(k);
      if (valid_q[idx] && issued_q[idx]) begin
        sb.rd_clobber[instr_q[idx].rd] = 1'b1;
        if (instr_q[idx].rd == sb.rs1) begin
          sb.rs1_fwd_data  = result_q[idx];
          sb.rs1_fwd_valid = done_q[idx];
        end
        if (instr_q[idx].rd == sb.rs2) begin
          sb.rs2_fwd_data  = result_q[idx];
          sb.rs2_fwd_valid = done_q[idx];
        end
      end
    end
    // x0 reads zero from the register file whatever is in flight
    sb.rd_clobber[0] = 1'b0;
  end

  // ------------------------------------------------
  // Slot state and pointers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q      <= '0;
      issued_q     <= '0;
      done_q       <= '0;
      wr_ptr_q     <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
    end else begin
      if (alloc) begin
        valid_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q          <= wr_ptr_q + ptr_t'(1);
      end
      if (issue_fire) begin
        issued_q[issue_ptr_q] <= 1'b1;
        issue_ptr_q           <= issue_ptr_q + ptr_t'(1);
      end
      if (wb_valid_i) begin
        done_q[wb_id] <= 1'b1;
      end
      // Freed slot goes back clean for the next allocation
      if (commit_fire) begin
        valid_q[commit_ptr_q]  <= 1'b0;
        issued_q[commit_ptr_q] <= 1'b0;
        done_q[commit_ptr_q]   <= 1'b0;
        commit_ptr_q           <= commit_ptr_q + ptr_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc) begin
      instr_q[wr_ptr_q] <= alloc_entry;
    end
    if (wb_valid_i) begin
      result_q[wb_id] <= wb_data_i;
    end
  end

  // ------------------------------------------------
  // Assertions
  // ------------------------------------------------
  // Units answer only for dispatched slots that still wait for a result
  a_wb_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> (int'(wb_trans_id_i) < NR_SB_ENTRIES) &&
                   valid_q[wb_id] && issued_q[wb_id] && !done_q[wb_id]);

  // All slots taken means the write pointer wrapped onto the head
  a_full_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (&valid_q) |-> !decoded_ready_o && (wr_ptr_q == commit_ptr_q));

endmodule

`default_nettype wire

/* hdl/sb_iro_if.sv */
// Scoreboard to operand-read interface with issue handshake, clobber vector and forwarding
`timescale 1ns/1ps
`default_nettype none

interface sb_iro_if import issue_pkg::*; #(
  parameter int unsigned NR_SB_ENTRIES = 4
) ();

  localparam int unsigned TID_W = $clog2(NR_SB_ENTRIES);

  // Oldest unissued entry and its slot index
  sb_entry_t                    issue_instr;
  logic [TID_W-1:0]             issue_id;
  logic                         issue_valid;
  logic                         issue_ack;

  // Registers with an issued, uncommitted producer
  logic [2**REG_ADDR_BITS-1:0]  rd_clobber;

  // Source lookup, answered in the same cycle
  logic [REG_ADDR_BITS-1:0]     rs1;
  logic [REG_ADDR_BITS-1:0]     rs2;
  logic [XLEN-1:0]              rs1_fwd_data;
  logic                         rs1_fwd_valid;
  logic [XLEN-1:0]              rs2_fwd_data;
  logic                         rs2_fwd_valid;

  modport sb (
    output issue_instr, issue_id, issue_valid, rd_clobber,
    output rs1_fwd_data, rs1_fwd_valid, rs2_fwd_data, rs2_fwd_valid,
    input  issue_ack, rs1, rs2
  );

  modport iro (
    input  issue_instr, issue_id, issue_valid, rd_clobber,
    input  rs1_fwd_data, rs1_fwd_valid, rs2_fwd_data, rs2_fwd_valid,
    output issue_ack, rs1, rs2
  );

endinterface

`default_nettype wire

/* hdl/issue_pkg.sv */
// Shared widths, operation and unit encodings, scoreboard entry and dispatch payload types
`default_nettype none

package issue_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned REG_ADDR_BITS = 5;
  // Sized for the largest scoreboard, 16 entries
  localparam int unsigned TRANS_ID_BITS = 4;

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------
  // ADD, SUB, AND and XOR go to the ALU, LDA to the LSU
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_LDA
  } op_t;

  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_LSU
  } fu_t;

  // Decoded instruction as held in one scoreboard slot
  typedef struct packed {
    op_t                      op;
    fu_t                      fu;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } sb_entry_t;

  // Payload handed to ALU or LSU
  typedef struct packed {
    op_t                      op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } fu_data_t;

endpackage

`default_nettype wire
